/* verilog/fp_arith_pkg.sv */
// fixed-point arithmetic unit shared widths, word types and enums
package fp_arith_pkg;

  // operand and result width
  localparam int DATA_WIDTH = 32;

  // binary point position used when the top level does not override it
  localparam int DEFAULT_FRAC_WIDTH = 16;

  // counts up to DATA_WIDTH plus the widest legal FRAC_WIDTH
  localparam int DIV_COUNT_WIDTH = $clog2(2 * DATA_WIDTH);

  typedef logic [DATA_WIDTH-1:0]   fp_word_t;  // one fixed-point word
  typedef logic [2*DATA_WIDTH-1:0] fp_wide_t;  // full product or scaled dividend

  typedef logic [DIV_COUNT_WIDTH-1:0] div_count_t;

  typedef enum logic [1:0] {
    op_add = 2'b00,
    op_sub = 2'b01,
    op_mul = 2'b10,
    op_div = 2'b11
  } fp_op_e;

  typedef enum logic [1:0] {
    div_idle   = 2'b00,
    div_run    = 2'b01,
    div_finish = 2'b10
  } div_state_e;

endpackage

/* verilog/fp_operand_if.sv */
// operand interface, carries one decoded request into the processing side
interface fp_operand_if;
  import fp_arith_pkg::*;

  logic     valid;   // one-cycle pulse per request
  fp_op_e   op;
  fp_word_t a_word;  // raw word for add/sub, magnitude for mul/div
  fp_word_t b_word;
  logic     neg_q;   // quotient or product comes out negated
  logic     neg_r;   // remainder comes out negated

  modport src (
    output valid,
    output op,
    output a_word,
    output b_word,
    output neg_q,
    output neg_r
  );

  modport dst (
    input valid,
    input op,
    input a_word,
    input b_word,
    input neg_q,
    input neg_r
  );

endinterface

/* verilog/fp_result_if.sv */
// result interface, carries raw results and sign flags to the output side
interface fp_result_if;
  import fp_arith_pkg::*;

  logic     valid;      // one-cycle pulse
  fp_word_t value;      // sum, difference, product or quotient
  fp_word_t rem_value;  // zero unless a division finished
  logic     neg_q;
  logic     neg_r;

  modport src (
    output valid,
    output value,
    output rem_value,
    output neg_q,
    output neg_r
  );

  modport dst (
    input valid,
    input value,
    input rem_value,
    input neg_q,
    input neg_r
  );

endinterface

/* verilog/fp_mult_pipe.sv */
// three-stage magnitude multiplier, product realigned to the binary point
module fp_mult_pipe #(
  parameter int FRAC_WIDTH = fp_arith_pkg::DEFAULT_FRAC_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   in_valid,
  input  fp_arith_pkg::fp_word_t a_mag,
  input  fp_arith_pkg::fp_word_t b_mag,
  output logic                   out_valid,
  output fp_arith_pkg::fp_word_t product
);
  import fp_arith_pkg::*;

  fp_word_t a_q;
  fp_word_t b_q;
  fp_wide_t prod_q;
  logic     s1_valid;
  logic     s2_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid  <= 1'b0;
      s2_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      s2_valid  <= s1_valid;
      out_valid <= s2_valid;
    end
  end

  always_ff @(posedge clk) begin
    // stage one, operands
    if (in_valid) begin
      a_q <= a_mag;
      b_q <= b_mag;
    end
    // stage two, full double-width product
    if (s1_valid) begin
      prod_q <= fp_wide_t'(a_q) * fp_wide_t'(b_q);
    end
    if (s2_valid) begin
      product <= prod_q[FRAC_WIDTH +: DATA_WIDTH];  // drop low fraction bits
    end
  end

endmodule

/* verilog/fp_div_iter.sv */
// restoring shift-subtract divider on the dividend scaled by 2^FRAC_WIDTH
module fp_div_iter #(
  parameter int FRAC_WIDTH = fp_arith_pkg::DEFAULT_FRAC_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   start,
  input  fp_arith_pkg::fp_word_t dividend,
  input  fp_arith_pkg::fp_word_t divisor,
  output logic                   out_valid,
  output fp_arith_pkg::fp_word_t quotient,
  output fp_arith_pkg::fp_word_t remainder
);
  import fp_arith_pkg::*;

  // one step per bit of the scaled dividend
  localparam int ITERATIONS = DATA_WIDTH + FRAC_WIDTH;

  div_state_e          state;
  div_count_t          count;
  fp_word_t            divisor_q;
  fp_word_t            acc;        // partial remainder
  fp_wide_t            shreg;      // dividend bits leave the top, quotient bits enter below
  logic [DATA_WIDTH:0] trial;
  logic                q_bit;
  fp_word_t            acc_next;
  logic                last_step;

  assign trial     = {acc, shreg[ITERATIONS-1]};
  assign q_bit     = (trial >= {1'b0, divisor_q});
  assign acc_next  = q_bit ? fp_word_t'(trial - {1'b0, divisor_q}) : trial[DATA_WIDTH-1:0];
  assign last_step = (count == div_count_t'(ITERATIONS - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= div_idle;
      count <= '0;
    end else begin
      case (state)
        div_idle: begin
          if (start) begin
            state <= div_run;
            count <= '0;
          end
        end
        div_run: begin
          count <= count + 1'b1;
          if (last_step) begin
            state <= div_finish;
          end
        end
        div_finish: state <= div_idle;  // result shown for one cycle
        default:    state <= div_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == div_idle && start) begin
      divisor_q <= divisor;
      acc       <= '0;
      shreg     <= fp_wide_t'(dividend) << FRAC_WIDTH;
    end else if (state == div_run) begin
      acc   <= acc_next;
      shreg <= {shreg[2*DATA_WIDTH-2:0], q_bit};
    end
  end

  // quotient may be wider than a word, only the low word is kept
  assign out_valid = (state == div_finish);
  assign quotient  = shreg[DATA_WIDTH-1:0];
  assign remainder = acc;

endmodule

/* verilog/fp_operand_stage.sv */
// request side of the arithmetic unit, takes go, tracks busy and registers operands
module fp_operand_stage #(
  parameter int FRAC_WIDTH = fp_arith_pkg::DEFAULT_FRAC_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   go,
  input  fp_arith_pkg::fp_op_e   op,
  input  logic                   is_signed,
  input  fp_arith_pkg::fp_word_t left,
  input  fp_arith_pkg::fp_word_t right,
  input  logic                   retire,
  output logic                   busy,
  fp_operand_if.src              opnd
);
  import fp_arith_pkg::*;

  logic     busy_q;
  logic     accept;
  logic     use_mag;
  logic     sign_l;
  logic     sign_r;
  fp_word_t left_mag;
  fp_word_t right_mag;

  // binary point has to sit inside the word
  if (FRAC_WIDTH < 0 || FRAC_WIDTH >= DATA_WIDTH) begin : g_frac_range
    $error("FRAC_WIDTH out of range for the data width");
  end

  assign accept = go && !busy;
  assign busy   = busy_q && !retire;  // low again in the done cycle

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q     <= 1'b0;
      opnd.valid <= 1'b0;
    end else begin
      opnd.valid <= accept;
      if (accept) begin
        busy_q <= 1'b1;
      end else if (retire) begin
        busy_q <= 1'b0;
      end
    end
  end

  // signed mul/div run on magnitudes, the sign is put back at the end
  assign use_mag   = is_signed && (op == op_mul || op == op_div);
  assign sign_l    = left[DATA_WIDTH-1];
  assign sign_r    = right[DATA_WIDTH-1];
  assign left_mag  = sign_l ? -left : left;
  assign right_mag = sign_r ? -right : right;

  always_ff @(posedge clk) begin
    if (accept) begin
      opnd.op <= op;
      if (use_mag) begin
        opnd.a_word <= left_mag;
        opnd.b_word <= right_mag;
        opnd.neg_q  <= sign_l ^ sign_r;
        opnd.neg_r  <= sign_l;  // remainder follows the dividend
      end else begin
        opnd.a_word <= left;
        opnd.b_word <= right;
        opnd.neg_q  <= 1'b0;
        opnd.neg_r  <= 1'b0;
      end
    end
  end

endmodule

/* verilog/fp_exec.sv */
// processing side, registered add/sub plus dispatch to multiplier and divider
module fp_exec #(
  parameter int FRAC_WIDTH = fp_arith_pkg::DEFAULT_FRAC_WIDTH
) (
  input  logic      clk,
  input  logic      rst_n,
  fp_operand_if.dst opnd,
  fp_result_if.src  res
);
  import fp_arith_pkg::*;

  logic     addsub_valid;
  fp_word_t addsub_q;
  logic     neg_q_q;
  logic     neg_r_q;
  logic     mul_start;
  logic     div_start;
  logic     mul_valid;
  logic     div_valid;
  fp_word_t mul_product;
  fp_word_t div_quotient;
  fp_word_t div_remainder;

  assign mul_start = opnd.valid && (opnd.op == op_mul);
  assign div_start = opnd.valid && (opnd.op == op_div);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      addsub_valid <= 1'b0;
    end else begin
      addsub_valid <= opnd.valid && (opnd.op == op_add || opnd.op == op_sub);
    end
  end

  // add/sub wrap, sign flags ride along until the unit finishes
  always_ff @(posedge clk) begin
    if (opnd.valid) begin
      addsub_q <= (opnd.op == op_sub) ? opnd.a_word - opnd.b_word
                                      : opnd.a_word + opnd.b_word;
      neg_q_q  <= opnd.neg_q;
      neg_r_q  <= opnd.neg_r;
    end
  end

  fp_mult_pipe #(
    .FRAC_WIDTH(FRAC_WIDTH)
  ) mult_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .in_valid (mul_start),
    .a_mag    (opnd.a_word),
    .b_mag    (opnd.b_word),
    .out_valid(mul_valid),
    .product  (mul_product)
  );

  fp_div_iter #(
    .FRAC_WIDTH(FRAC_WIDTH)
  ) div_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .start    (div_start),
    .dividend (opnd.a_word),
    .divisor  (opnd.b_word),
    .out_valid(div_valid),
    .quotient (div_quotient),
    .remainder(div_remainder)
  );

  assign res.valid = addsub_valid || mul_valid || div_valid;
  assign res.neg_q = neg_q_q;
  assign res.neg_r = neg_r_q;

  always_comb begin
    res.value     = addsub_q;
    res.rem_value = '0;
    if (div_valid) begin
      res.value     = div_quotient;
      res.rem_value = div_remainder;
    end else if (mul_valid) begin
      res.value = mul_product;
    end
  end

endmodule

/* verilog/fp_result_stage.sv */
// output side, restores signs, registers the result and pulses done
module fp_result_stage (
  input  logic                   clk,
  input  logic                   rst_n,
  fp_result_if.dst               res,
  output logic                   retire,
  output logic                   done,
  output fp_arith_pkg::fp_word_t result,
  output fp_arith_pkg::fp_word_t remainder
);
  import fp_arith_pkg::*;

  fp_word_t value_signed;
  fp_word_t rem_signed;

  // two's complement negation where the operand stage asked for it
  assign value_signed = res.neg_q ? -res.value : res.value;
  assign rem_signed   = res.neg_r ? -res.rem_value : res.rem_value;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      done      <= 1'b0;
      result    <= '0;
      remainder <= '0;
    end else begin
      done <= res.valid;
      if (res.valid) begin
        result    <= value_signed;
        remainder <= rem_signed;  // held until the next done
      end
    end
  end

  // the request side frees up on the same cycle done is seen
  assign retire = done;

endmodule

/* verilog/fp_arith_unit.sv */
// fixed-point arithmetic unit top, add/sub/mul/div with a go/done handshake
module fp_arith_unit #(
  parameter int FRAC_WIDTH = fp_arith_pkg::DEFAULT_FRAC_WIDTH
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   go,
  input  fp_arith_pkg::fp_op_e   op,
  input  logic                   is_signed,
  input  fp_arith_pkg::fp_word_t left,
  input  fp_arith_pkg::fp_word_t right,
  output logic                   busy,
  output logic                   done,
  output fp_arith_pkg::fp_word_t result,
  output fp_arith_pkg::fp_word_t remainder
);

  logic retire;  // result stage back to request side

  fp_operand_if opnd_if ();
  fp_result_if  res_if ();

  fp_operand_stage #(
    .FRAC_WIDTH(FRAC_WIDTH)
  ) operand_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .go       (go),
    .op       (op),
    .is_signed(is_signed),
    .left     (left),
    .right    (right),
    .retire   (retire),
    .busy     (busy),
    .opnd     (opnd_if.src)
  );

  fp_exec #(
    .FRAC_WIDTH(FRAC_WIDTH)
  ) exec_i (
    .clk  (clk),
    .rst_n(rst_n),
    .opnd (opnd_if.dst),
    .res  (res_if.src)
  );

  fp_result_stage result_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .res      (res_if.dst),
    .retire   (retire),
    .done     (done),
    .result   (result),
    .remainder(remainder)
  );

endmodule

/* verif/fp_arith_model.svh */
// reference model for the fixed-point unit, expected result and remainder per request

// magnitude of a word, read as two's complement when is_signed is set
function automatic longint unsigned word_mag(input fp_word_t w, input logic is_signed_w);
  longint v;
  v = is_signed_w ? longint'($signed(w)) : longint'(w);
  if (v < 0) begin
    v = -v;
  end
  return v;
endfunction

// returns {result, remainder} as the unit should present them at done
function automatic logic [2*DATA_WIDTH-1:0] expected_pair(input fp_op_e o, input logic s,
                                                         input fp_word_t a, input fp_word_t b);
  longint unsigned ma;
  longint unsigned mb;
  longint unsigned full;
  fp_word_t res_w;
  fp_word_t rem_w;
  logic neg_q;
  logic neg_r;
  ma    = word_mag(a, s);
  mb    = word_mag(b, s);
  neg_q = s && (a[DATA_WIDTH-1] != b[DATA_WIDTH-1]);  // operand signs differ
  neg_r = s && a[DATA_WIDTH-1];                       // remainder takes the dividend sign
  rem_w = '0;
  case (o)
    op_add: res_w = a + b;  // wraps modulo 2^DATA_WIDTH
    op_sub: res_w = a - b;
    op_mul: begin
      full  = ma * mb;
      res_w = fp_word_t'(full >> FRAC_WIDTH);
      if (neg_q) res_w = -res_w;
    end
    default: begin
      full  = ma << FRAC_WIDTH;  // scaled dividend
      res_w = fp_word_t'(full / mb);
      rem_w = fp_word_t'(full % mb);
      if (neg_q) res_w = -res_w;
      if (neg_r) rem_w = -rem_w;
    end
  endcase
  return {res_w, rem_w};
endfunction

/* verif/fp_arith_tb.sv */
// testbench for the fixed-point arithmetic unit, random requests checked against a model
module fp_arith_tb;
  import fp_arith_pkg::*;

  localparam int FRAC_WIDTH  = DEFAULT_FRAC_WIDTH;
  localparam int SLOTS_5     = 120;  // offer cycles in the go stress test
  localparam int CYCLE_LIMIT = (200 + 200 + 100 + SLOTS_5) * (DATA_WIDTH + FRAC_WIDTH + 6);

  logic     clk;
  logic     rst_n;
  logic     go;
  fp_op_e   op;
  logic     is_signed;
  fp_word_t left;
  fp_word_t right;
  logic     busy;
  logic     done;
  fp_word_t result;
  fp_word_t remainder;

  integer seed = 32'hbccb;
  int     errors = 0;
  int     accepted = 0;
  int     done_count = 0;
  int     ignored = 0;
  int     cycle_count = 0;
  int     errors_before;
  logic [2*DATA_WIDTH-1:0] pending[$];  // {result, remainder} per accepted request

  `include "fp_arith_model.svh"

  fp_arith_unit #(
    .FRAC_WIDTH(FRAC_WIDTH)
  ) dut_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .go       (go),
    .op       (op),
    .is_signed(is_signed),
    .left     (left),
    .right    (right),
    .busy     (busy),
    .done     (done),
    .result   (result),
    .remainder(remainder)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycle_count++;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: no done after %0d cycles, the DUT appears to hang", cycle_count);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic flip_coin();
    logic [31:0] r;
    r = $random(seed);
    return r[0];
  endfunction

  // mix of small, near full scale and fully random words
  function automatic fp_word_t pick_operand();
    logic [31:0] r;
    logic [31:0] kind;
    r    = $random(seed);
    kind = $random(seed);
    case (kind[2:0])
      3'd0:    return fp_word_t'(r[7:0]);
      3'd1:    return 32'h7fff_ff00 | fp_word_t'(r[7:0]);
      3'd2:    return 32'h8000_0000 | fp_word_t'(r[7:0]);
      3'd3:    return 32'hffff_ff00 | fp_word_t'(r[7:0]);
      default: return r;
    endcase
  endfunction

  function automatic fp_word_t pick_divisor();
    fp_word_t w;
    do begin
      w = pick_operand();
    end while (w == '0);
    return w;
  endfunction

  task automatic check_done();
    logic [2*DATA_WIDTH-1:0] exp;
    assert (pending.size() != 0) else begin
      $display("done pulsed at time %0t with no request in flight", $time);
      errors++;
    end
    if (pending.size() != 0) begin
      exp = pending.pop_front();
      done_count++;
      assert (result == exp[2*DATA_WIDTH-1:DATA_WIDTH] && remainder == exp[DATA_WIDTH-1:0])
      else begin
        $display("Fail at time %0t: got %h rem %h, expected %h rem %h", $time, result,
                 remainder, exp[2*DATA_WIDTH-1:DATA_WIDTH], exp[DATA_WIDTH-1:0]);
        errors++;
      end
    end
  endtask

  // sampled at the falling edge where inputs and outputs are stable
  always @(negedge clk) begin
    if (rst_n) begin
      if (done) check_done();
      // busy from the cycle after acceptance up to, not including, the done cycle
      assert (busy == (pending.size() != 0)) else begin
        $display("Fail at time %0t: busy is %b with %0d requests in flight", $time, busy,
                 pending.size());
        errors++;
      end
      if (go && pending.size() != 0) ignored++;
      if (go && pending.size() == 0) begin
        pending.push_back(expected_pair(op, is_signed, left, right));
        accepted++;
      end
    end
  end

  task automatic issue(input fp_op_e o, input logic s, input fp_word_t a, input fp_word_t b);
    @(posedge clk);
    go        <= 1'b1;
    op        <= o;
    is_signed <= s;
    left      <= a;
    right     <= b;
    @(posedge clk);
    go <= 1'b0;
    while (pending.size() != 0) @(posedge clk);
  endtask

  task automatic offer_random_request();
    logic [31:0] r;
    r = $random(seed);
    op        <= fp_op_e'(r[1:0]);
    is_signed <= r[2];
    left      <= pick_operand();
    right     <= pick_divisor();
  endtask

  initial begin
    rst_n = 1'b0;
    go = 1'b0;
    op = op_add;
    is_signed = 1'b0;
    left = '0;
    right = '0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    errors_before = errors;
    repeat (2) @(posedge clk);
    @(negedge clk);
    assert (!busy && !done && result == '0 && remainder == '0) else begin
      $display("Fail at time %0t: outputs not idle after reset", $time);
      errors++;
    end
    $display("test 1 reset values: %0d errors", errors - errors_before);

    errors_before = errors;
    repeat (200) issue(flip_coin() ? op_sub : op_add, flip_coin(), pick_operand(), pick_operand());
    $display("test 2 add/sub: %0d errors", errors - errors_before);

    errors_before = errors;
    repeat (200) issue(op_mul, flip_coin(), pick_operand(), pick_operand());
    $display("test 3 mul: %0d errors", errors - errors_before);

    errors_before = errors;
    repeat (100) issue(op_div, flip_coin(), pick_operand(), pick_divisor());
    $display("test 4 div: %0d errors", errors - errors_before);

    errors_before = errors;
    repeat (SLOTS_5 / 2) begin  // go held high
      @(posedge clk);
      go <= 1'b1;
      offer_random_request();
    end
    repeat (SLOTS_5 / 2) begin  // random go pulses, most land while busy
      @(posedge clk);
      go <= flip_coin();
      offer_random_request();
    end
    @(posedge clk);
    go <= 1'b0;
    while (pending.size() != 0) @(posedge clk);
    repeat (DATA_WIDTH + FRAC_WIDTH + 6) @(posedge clk);  // a stray done would show here
    assert (accepted == done_count && ignored > 0) else begin
      $display("%0d requests accepted but %0d results, %0d ignored", accepted, done_count,
               ignored);
      errors++;
    end
    $display("test 5 go while busy: %0d errors", errors - errors_before);

    $display("%0d accepted, %0d checked, %0d ignored, %0d errors", accepted, done_count,
             ignored, errors);
    if (errors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+verif
verilog/fp_arith_pkg.sv
verilog/fp_operand_if.sv
verilog/fp_result_if.sv
verilog/fp_mult_pipe.sv
verilog/fp_div_iter.sv
verilog/fp_operand_stage.sv
verilog/fp_exec.sv
verilog/fp_result_stage.sv
verilog/fp_arith_unit.sv
verif/fp_arith_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= fp_arith_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= Test passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)
